// File: pf_defines.svh
////////////////////
// Prefetch buffer widths and constants
// Address, word and halfword sizes, the full-instruction marker and PC steps
////////////////////

`ifndef PF_DEFINES_SVH
`define PF_DEFINES_SVH

////////////////////
// Widths

`define PF_ADDR_W 32 // Byte address into instruction memory
`define PF_WORD_W 32 // One memory word and one output instruction
`define PF_HALF_W 16 // One compressed instruction or half of a full one

////////////////////
// Encoding

// Low two bits of a full 32-bit instruction, anything else is compressed
`define PF_FULL_MARK 2'b11

`define PF_STEP_C 2 // PC advance after a compressed instruction
`define PF_STEP_F 4 // PC advance after a full instruction

`endif

// File: pf_fetch_ctrl.sv
////////////////////
// Prefetch memory controller
// Request FSM towards instruction memory, fetch address and branch abort
////////////////////

`include "pf_defines.svh"

module pf_fetch_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,

  // Decode side
  input  logic                  req_i,          // Decode wants instructions
  input  logic                  branch_i,       // Redirect fetch to branch_addr_i
  input  logic [`PF_ADDR_W-1:0] branch_addr_i,

  // Instruction memory
  output logic                  mem_req_o,
  output logic [`PF_ADDR_W-1:0] mem_addr_o,     // Always word aligned
  input  logic                  mem_gnt_i,
  input  logic [`PF_WORD_W-1:0] mem_rdata_i,
  input  logic                  mem_rvalid_i,

  // Status and instruction address
  output logic                  busy_o,
  output logic [`PF_ADDR_W-1:0] instr_addr_o,

  pf_fetch_if.ctrl              fetch_if
);

  ////////////////////
  // Declarations

  typedef enum logic [1:0] {
    ST_IDLE,        // No request in flight
    ST_WAIT_GNT,    // Request raised, memory has not granted yet
    ST_WAIT_RVALID, // Granted, response still to come
    ST_ABORTED      // Granted before a branch, response gets swallowed
  } state_e;

  state_e                state_q, state_d;

  logic [`PF_ADDR_W-1:0] fetch_addr_q, fetch_addr_d; // Next instruction, or next word in a straddle
  logic [`PF_ADDR_W-1:0] straddle_addr_q;            // Start of the instruction being split
  logic                  straddle_pend_q, straddle_pend_d;

  logic                  issue;   // New request raised from idle
  logic [`PF_ADDR_W-1:0] step;    // Size of the instruction leaving this cycle

  ////////////////////
  // Memory side

  // Only ask for a word when the aligner has run dry and decode is fetching
  assign issue = (state_q == ST_IDLE) && req_i && fetch_if.need_word && !branch_i;

  assign mem_req_o  = issue || (state_q == ST_WAIT_GNT);
  assign mem_addr_o = {fetch_addr_q[`PF_ADDR_W-1:2], 2'b00};

  // Something is pending or outstanding whenever we are not idle
  assign busy_o = (state_q != ST_IDLE) || mem_req_o;

  // A response is passed on only if it was not overtaken by a branch
  assign fetch_if.resp_valid = (state_q == ST_WAIT_RVALID) && mem_rvalid_i && !branch_i;
  assign fetch_if.resp_word  = mem_rdata_i;
  assign fetch_if.fetch_half = fetch_addr_q[1];
  assign fetch_if.flush      = branch_i;

  ////////////////////
  // Request FSM

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      ST_IDLE: begin
        if (issue) begin
          state_d = mem_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      ST_WAIT_GNT: begin
        // A grant in the branch cycle still leaves a response to drop
        if (mem_gnt_i) begin
          state_d = branch_i ? ST_ABORTED : ST_WAIT_RVALID;
        end else if (branch_i) begin
          state_d = ST_IDLE; // Request withdrawn before it was accepted
        end
      end

      ST_WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          state_d = ST_IDLE; // Word goes to the aligner unless a branch hides it
        end else if (branch_i) begin
          state_d = ST_ABORTED;
        end
      end

      ST_ABORTED: begin
        if (mem_rvalid_i) begin
          state_d = ST_IDLE; // Stale word is swallowed here
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  ////////////////////
  // Fetch address

  // While the second half of a straddling instruction is fetched, decode sees its start
  assign instr_addr_o = straddle_pend_q ? straddle_addr_q : fetch_addr_q;

  assign step = fetch_if.step_full ? `PF_ADDR_W'(`PF_STEP_F) : `PF_ADDR_W'(`PF_STEP_C);

  always_comb begin
    fetch_addr_d    = fetch_addr_q;
    straddle_pend_d = straddle_pend_q;

    if (branch_i) begin
      fetch_addr_d    = branch_addr_i; // Branch wins over anything the aligner reports
      straddle_pend_d = 1'b0;
    end else if (fetch_if.straddle_start) begin
      // Move on to the word holding the upper part, start address is kept aside
      fetch_addr_d    = fetch_addr_q + `PF_ADDR_W'(`PF_STEP_C);
      straddle_pend_d = 1'b1;
    end else if (fetch_if.out_fire) begin
      fetch_addr_d    = instr_addr_o + step;
      straddle_pend_d = 1'b0;
    end
  end

  ////////////////////
  // Registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q         <= ST_IDLE;
      fetch_addr_q    <= '0;
      straddle_pend_q <= 1'b0;
    end else begin
      state_q         <= state_d;
      fetch_addr_q    <= fetch_addr_d;
      straddle_pend_q <= straddle_pend_d;
    end
  end

  // Only read while straddle_pend_q is set
  always_ff @(posedge clk) begin
    if (!branch_i && fetch_if.straddle_start) begin
      straddle_addr_q <= fetch_addr_q;
    end
  end

endmodule

// File: pf_fetch_if.sv
////////////////////
// Controller to aligner link
// Response handoff from memory side, format feedback from decode side
////////////////////

`include "pf_defines.svh"

interface pf_fetch_if;

  // Driven by the memory-side controller
  logic                  resp_valid;     // One-cycle pulse with a response that is kept
  logic [`PF_WORD_W-1:0] resp_word;      // Raw word from memory
  logic                  fetch_half;     // Bit 1 of the current fetch address
  logic                  flush;          // Branch, drop all buffered state

  // Driven by the aligner
  logic                  out_fire;       // Instruction handed to decode this cycle
  logic                  step_full;      // That instruction was 4 bytes long
  logic                  need_word;      // Nothing can be presented without a new word
  logic                  straddle_start; // Lower part of a full instruction captured

  modport ctrl (
    output resp_valid,
    output resp_word,
    output fetch_half,
    output flush,
    input  out_fire,
    input  step_full,
    input  need_word,
    input  straddle_start
  );

  modport align (
    input  resp_valid,
    input  resp_word,
    input  fetch_half,
    input  flush,
    output out_fire,
    output step_full,
    output need_word,
    output straddle_start
  );

endinterface

// File: pf_instr_aligner.sv
////////////////////
// Prefetch instruction aligner
// Holds the response word and one halfword, builds 16/32-bit instructions
////////////////////

`include "pf_defines.svh"

module pf_instr_aligner (
  input  logic                  clk,
  input  logic                  rst_n,

  // Decode side
  input  logic                  ready_i,
  output logic                  valid_o,
  output logic [`PF_WORD_W-1:0] instr_o,

  pf_fetch_if.align             fetch_if
);

  ////////////////////
  // Declarations

  pf_pkg::fetch_word_u   word_q;       // Last response word
  logic                  word_valid_q; // Word not used yet
  logic [`PF_HALF_W-1:0] held_q;       // Upper half of an earlier word
  logic                  held_valid_q;
  logic                  straddle_q;   // held_q is the lower part of a full instruction

  pf_pkg::instr_fmt_e    fmt;
  logic                  present;      // An instruction can be shown to decode
  logic                  split;        // A full instruction starts in an upper half
  logic                  keep_hi;      // Upper half of word_q moves into held_q

  logic                  lo_full, hi_full, held_full;

  assign lo_full   = (word_q.half.lo[1:0] == `PF_FULL_MARK);
  assign hi_full   = (word_q.half.hi[1:0] == `PF_FULL_MARK);
  assign held_full = (held_q[1:0] == `PF_FULL_MARK);

  ////////////////////
  // Format decision

  always_comb begin
    fmt     = pf_pkg::FMT_FULL_ALIGNED;
    present = 1'b0;
    split   = 1'b0;

    if (word_valid_q) begin
      if (straddle_q) begin
        fmt     = pf_pkg::FMT_FULL_STRADDLE; // Second fetch of a split instruction is here
        present = 1'b1;
      end else if (!fetch_if.fetch_half) begin
        fmt     = lo_full ? pf_pkg::FMT_FULL_ALIGNED : pf_pkg::FMT_C_ALIGNED;
        present = 1'b1;
      end else if (!hi_full) begin
        fmt     = pf_pkg::FMT_C_MISALIGNED; // First word after a branch to a misaligned target
        present = 1'b1;
      end else begin
        split   = 1'b1;
      end
    end else if (held_valid_q && fetch_if.fetch_half && !straddle_q) begin
      // Sequential flow into the upper half, no memory access unless it is a full one
      if (!held_full) begin
        fmt     = pf_pkg::FMT_C_HELD;
        present = 1'b1;
      end else begin
        split   = 1'b1;
      end
    end
  end

  // Compressed instructions leave zero-extended
  always_comb begin
    unique case (fmt)
      pf_pkg::FMT_FULL_ALIGNED:  instr_o = word_q.full;
      pf_pkg::FMT_C_ALIGNED:     instr_o = {{`PF_HALF_W{1'b0}}, word_q.half.lo};
      pf_pkg::FMT_C_MISALIGNED:  instr_o = {{`PF_HALF_W{1'b0}}, word_q.half.hi};
      pf_pkg::FMT_C_HELD:        instr_o = {{`PF_HALF_W{1'b0}}, held_q};
      pf_pkg::FMT_FULL_STRADDLE: instr_o = {word_q.half.lo, held_q};
      default:                   instr_o = word_q.full;
    endcase
  end

  ////////////////////
  // Handshake and feedback

  assign valid_o  = present && !fetch_if.flush; // Branch drops what is on show
  assign fetch_if.out_fire  = valid_o && ready_i;
  assign fetch_if.step_full = (fmt == pf_pkg::FMT_FULL_ALIGNED) ||
                              (fmt == pf_pkg::FMT_FULL_STRADDLE);
  assign fetch_if.need_word = !present && !split;
  assign fetch_if.straddle_start = split && !fetch_if.flush;

  // The upper half stays useful after a lower compressed one, a straddle, or a split start
  assign keep_hi = (fetch_if.out_fire && ((fmt == pf_pkg::FMT_C_ALIGNED) ||
                                          (fmt == pf_pkg::FMT_FULL_STRADDLE))) ||
                   (fetch_if.straddle_start && word_valid_q);

  ////////////////////
  // Registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid_q <= 1'b0;
      held_valid_q <= 1'b0;
      straddle_q   <= 1'b0;
    end else if (fetch_if.flush) begin
      word_valid_q <= 1'b0;
      held_valid_q <= 1'b0;
      straddle_q   <= 1'b0;
    end else begin
      if (fetch_if.resp_valid) begin
        word_valid_q <= 1'b1;
      end else if (fetch_if.out_fire || split) begin
        word_valid_q <= 1'b0; // Stored word fully consumed
      end

      if (fetch_if.out_fire) begin
        held_valid_q <= keep_hi;
        straddle_q   <= 1'b0;
      end else if (split) begin
        held_valid_q <= 1'b1;
        straddle_q   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_if.resp_valid) begin
      word_q <= fetch_if.resp_word;
    end
    if (keep_hi) begin
      held_q <= word_q.half.hi;
    end
  end

endmodule

// File: pf_pkg.sv
////////////////////
// Prefetch buffer types
// Fetched word view and instruction format codes
////////////////////

`include "pf_defines.svh"

package pf_pkg;

  ////////////////////
  // Memory word

  // Upper and lower halfword of one fetched word, lower half sits at the lower address
  typedef struct packed {
    logic [`PF_HALF_W-1:0] hi; // Halfword at word address + 2
    logic [`PF_HALF_W-1:0] lo; // Halfword at word address + 0
  } half_pair_t;

  // The same word is looked at as one full instruction or as two halves
  typedef union packed {
    logic [`PF_WORD_W-1:0] full; // Aligned 32-bit instruction
    half_pair_t            half; // Two compressed instructions or instruction parts
  } fetch_word_u;

  ////////////////////
  // Output formats

  //                          upper  lower
  // FMT_FULL_ALIGNED       [ iiii , iiii ] stored word
  // FMT_C_ALIGNED          [ xxxx , iiii ] stored word
  // FMT_C_MISALIGNED       [ iiii , xxxx ] stored word
  // FMT_C_HELD             [ iiii , xxxx ] held half
  // FMT_FULL_STRADDLE      lower part held, upper part from the lower half of the new word
  typedef enum logic [2:0] {
    FMT_FULL_ALIGNED,
    FMT_C_ALIGNED,
    FMT_C_MISALIGNED,
    FMT_C_HELD,
    FMT_FULL_STRADDLE
  } instr_fmt_e;

endpackage

// File: prefetch_buffer_small.sv
////////////////////
// Small instruction prefetch buffer
// Word fetch from memory, one held halfword, 16/32-bit instructions to decode
////////////////////

`include "pf_defines.svh"

module prefetch_buffer_small (
  input  logic                  clk,
  input  logic                  rst_n,

  ////////////////////
  // Decode side

  input  logic                  req_i,         // Keep fetching
  input  logic                  branch_i,      // Restart at branch_addr_i
  input  logic [`PF_ADDR_W-1:0] branch_addr_i, // Halfword aligned target
  input  logic                  ready_i,
  output logic                  valid_o,
  output logic [`PF_WORD_W-1:0] instr_o,       // Compressed ones are zero-extended
  output logic [`PF_ADDR_W-1:0] instr_addr_o,

  ////////////////////
  // Instruction memory

  output logic                  mem_req_o,
  output logic [`PF_ADDR_W-1:0] mem_addr_o,
  input  logic                  mem_gnt_i,
  input  logic [`PF_WORD_W-1:0] mem_rdata_i,
  input  logic                  mem_rvalid_i,

  output logic                  busy_o         // Request pending or outstanding
);

  // Link between memory-side control and decode-side alignment
  pf_fetch_if fetch_if ();

  // Owns the memory protocol and the program counter
  pf_fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .busy_o        (busy_o),
    .instr_addr_o  (instr_addr_o),
    .fetch_if      (fetch_if.ctrl)
  );

  // Owns the word buffer, the held half and the instruction format
  pf_instr_aligner u_instr_aligner (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .instr_o  (instr_o),
    .fetch_if (fetch_if.align)
  );

endmodule

// File: sim.f
+incdir+.
pf_pkg.sv
pf_fetch_if.sv
pf_fetch_ctrl.sv
pf_instr_aligner.sv
prefetch_buffer_small.sv
tb_mem_model.sv
tb_prefetch.sv

// File: tb_mem_model.sv
////////////////////
// Instruction memory model
// Random grant and response delays over a halfword program image
////////////////////

module tb_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic [1:0]  gnt_dly_i,   // Grant delay for the next request, 0 to 3 cycles
  input  logic [1:0]  rsp_dly_i,   // Response delay, 0 and 1 both mean one cycle
  output logic        gnt_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  output logic        outst_o,     // Granted and not answered yet
  output logic        proto_err_o  // Second request seen while one was outstanding
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [15:0] image [1024];       // Halfword image, filled by the testbench
  logic [1:0]  wait_q, gnt_lim_q;  // Cycles the request has waited, and the goal
  logic [1:0]  rsp_left_q;
  logic [31:0] raddr_q;            // Address latched at grant
  logic [9:0]  idx;

  assign idx      = raddr_q[10:1]; // Even index, the image wraps every 2 KB
  assign gnt_o    = req_i && !outst_o && (wait_q >= gnt_lim_q);
  assign rvalid_o = outst_o && (rsp_left_q == 2'd1);
  assign rdata_o  = {image[idx + 10'd1], image[idx]}; // Lower address in the low half

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q      <= '0;
      gnt_lim_q   <= '0;
      rsp_left_q  <= '0;
      raddr_q     <= '0;
      outst_o     <= 1'b0;
      proto_err_o <= 1'b0;
    end else begin
      // A withdrawn or granted request starts the count over
      if (!req_i || gnt_o) begin
        wait_q    <= '0;
        gnt_lim_q <= gnt_dly_i;
      end else if (wait_q != 2'd3) begin
        wait_q <= wait_q + 2'd1;
      end
      if (gnt_o) begin
        outst_o    <= 1'b1;
        raddr_q    <= addr_i;
        rsp_left_q <= (rsp_dly_i == 2'd0) ? 2'd1 : rsp_dly_i;
      end else if (outst_o) begin
        if (rsp_left_q == 2'd1) outst_o <= 1'b0; // Answered this cycle
        else rsp_left_q <= rsp_left_q - 2'd1;
      end
      if (req_i && outst_o) proto_err_o <= 1'b1; // Sticky, the testbench reports it
    end
  end

endmodule

// File: tb_prefetch.sv
////////////////////
// Prefetch buffer testbench
// Random memory timing, back-pressure and branches against a stream model
////////////////////

`include "pf_defines.svh"

module tb_prefetch;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_INSTR  = 600; // Transfers to check
  localparam int WAIT_MAX = 200; // Cycles allowed for one transfer

  logic        clk, rst_n, req, branch, ready, valid, busy;
  logic [31:0] branch_addr, instr, instr_addr;
  logic        mem_req, mem_gnt, mem_rvalid, mem_outst, mem_err;
  logic [31:0] mem_addr, mem_rdata;
  logic [1:0]  gnt_dly, rsp_dly;
  logic [31:0] lfsr = 32'd67812;
  logic [31:0] exp_addr, hold_instr, hold_addr; // Model PC and the instruction on hold
  logic        hold_q;                         // Last cycle ended with valid and no ready
  int          n_full = 0, n_c_al = 0, n_c_mis = 0, n_strad = 0;
  int          n_hold = 0, n_br_out = 0;

  always #10 clk = ~clk;

  prefetch_buffer_small UUT (
    .clk (clk), .rst_n (rst_n), .req_i (req), .branch_i (branch),
    .branch_addr_i (branch_addr), .ready_i (ready), .valid_o (valid),
    .instr_o (instr), .instr_addr_o (instr_addr), .mem_req_o (mem_req),
    .mem_addr_o (mem_addr), .mem_gnt_i (mem_gnt), .mem_rdata_i (mem_rdata),
    .mem_rvalid_i (mem_rvalid), .busy_o (busy)
  );

  tb_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (mem_req), .addr_i (mem_addr),
    .gnt_dly_i (gnt_dly), .rsp_dly_i (rsp_dly), .gnt_o (mem_gnt), .rdata_o (mem_rdata),
    .rvalid_o (mem_rvalid), .outst_o (mem_outst), .proto_err_o (mem_err)
  );

  // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Instruction starting at addr as the image holds it
  function automatic logic [31:0] expected_instr(input logic [31:0] addr);
    logic [15:0] lo, hi;
    lo = u_mem.image[addr[10:1]];
    hi = u_mem.image[addr[10:1] + 10'd1]; // Next halfword may sit in the next word
    if (lo[1:0] == `PF_FULL_MARK) return {hi, lo};
    return {16'h0000, lo};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Drive on the rising edge and judge the settled outputs on the falling edge
  task automatic step_cycle(output bit fired);
    logic [31:0] exp_instr;
    logic [31:0] exp_word;
    string       kind;
    fired = 1'b0;
    @(posedge clk);
    req         <= 1'b1;
    ready       <= (rand_bits(2) != 0);   // Stall about one cycle in four
    branch      <= (rand_bits(5) == 0);
    branch_addr <= rand_bits(10) << 1;    // Halfword aligned inside the image
    gnt_dly     <= 2'(rand_bits(2));
    rsp_dly     <= 2'(rand_bits(2));
    @(negedge clk);
    if (mem_err) begin
      $display("memory model got a second request while one was still outstanding");
      $display("sim failed");
      $fatal(1, "memory protocol violation");
    end
    check_value("busy_o", mem_req || mem_outst, busy);
    if (mem_req) begin
      // The word at the model PC, or the following one for the upper part of a split full one
      exp_word  = {exp_addr[31:2], 2'b00};
      exp_instr = expected_instr(exp_addr);
      if (exp_addr[1] && (exp_instr[1:0] == `PF_FULL_MARK) && (mem_addr != exp_word)) begin
        exp_word = exp_word + 32'd4;
      end
      check_value("mem_addr_o", exp_word, mem_addr);
    end
    if (branch) begin
      check_value("valid_o during branch", 0, valid); // Presented instruction is dropped
      exp_addr = branch_addr;
      hold_q   = 1'b0;
      if (mem_outst) n_br_out++;
    end else begin
      if (hold_q) begin
        n_hold++;
        check_value("valid_o under back-pressure", 1, valid);
        check_value("instr_o under back-pressure", hold_instr, instr);
        check_value("instr_addr_o under back-pressure", hold_addr, instr_addr);
        check_value("mem_req_o under back-pressure", 0, mem_req);
      end
      if (valid && ready) begin
        exp_instr = expected_instr(exp_addr);
        if (exp_instr[1:0] == `PF_FULL_MARK) begin
          if (exp_addr[1]) begin
            kind = "straddling full";
            n_strad++;
          end else begin
            kind = "aligned full";
            n_full++;
          end
        end else begin
          if (exp_addr[1]) begin
            kind = "misaligned compressed";
            n_c_mis++;
          end else begin
            kind = "aligned compressed";
            n_c_al++;
          end
        end
        check_value($sformatf("%s instr_addr_o", kind), exp_addr, instr_addr);
        check_value($sformatf("%s instr_o", kind), exp_instr, instr);
        exp_addr = exp_addr + ((exp_instr[1:0] == `PF_FULL_MARK) ? `PF_STEP_F : `PF_STEP_C);
        fired    = 1'b1;
      end
      hold_q     = valid && !ready;
      hold_instr = instr;
      hold_addr  = instr_addr;
    end
  endtask

  initial begin
    logic [15:0] half;
    bit          fired;
    int          waited;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    ready       = 1'b0;
    branch_addr = '0;
    gnt_dly     = '0;
    rsp_dly     = '0;
    exp_addr    = '0;
    hold_q      = 1'b0;
    hold_instr  = '0;
    hold_addr   = '0;
    // Roughly three halfwords in eight of the program image start a compressed instruction
    for (int i = 0; i < 1024; i++) begin
      half = 16'(rand_bits(16));
      if (rand_bits(3) < 3) begin
        if (half[1:0] == `PF_FULL_MARK) half[1:0] = 2'b00;
      end else begin
        half[1:0] = `PF_FULL_MARK;
      end
      u_mem.image[i] = half;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("valid_o in reset", 0, valid);
    check_value("mem_req_o in reset", 0, mem_req);
    check_value("busy_o in reset", 0, busy);
    @(posedge clk);
    rst_n <= 1'b1;                        // Fourth rising edge ends the reset
    @(negedge clk);
    check_value("valid_o after reset", 0, valid);
    check_value("mem_req_o after reset", 0, mem_req);
    check_value("busy_o after reset", 0, busy);
    for (int n = 0; n < N_INSTR; n++) begin
      waited = 0;
      fired  = 1'b0;
      while (!fired) begin
        if (waited == WAIT_MAX) begin
          $display("no instruction transfer within %0d cycles for transfer %0d", WAIT_MAX, n);
          $display("sim failed");
          $fatal(1, "handshake timeout");
        end
        step_cycle(fired);
        waited++;
      end
    end
    if (n_full == 0 || n_c_al == 0 || n_c_mis == 0 || n_strad == 0 ||
        n_hold == 0 || n_br_out == 0) begin
      $display("stimulus missed an instruction format, a stall or a branch over a fetch");
      $display("sim failed");
      $fatal(1, "stimulus incomplete");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule
